// File: mode_selection.f
+incdir+testbench
common/sram_cfg_pkg.sv
common/sram_port_pkg.sv
src/mode_decoder.sv
src/bank_select.sv
side_router/side_router.sv
src/mode_selection.sv
testbench/tb_mode_selection.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the SRAM router testbench with Verilator, runs it and scans the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_mode_selection \
   -f mode_selection.f \
   -o sim_mode_selection

./obj_dir/sim_mode_selection 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
echo "simulation passed"

// File: testbench/tb_ref_model.svh
/* Reference model of the SRAM port router, included by the testbench.
   ref_route gives every routed output for one configuration and four port requests. */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
   sram_port_pkg::macro_port_t [3:0] macro_a;
   sram_port_pkg::macro_port_t [3:0] macro_b;
   sram_port_pkg::port_sel_t [3:0]   sel;
   logic                             casc_a;
   logic                             casc_b;
} route_t;

function automatic route_t ref_route(input sram_cfg_pkg::sram_cfg_t        cfg,
                                     input sram_port_pkg::port_req_t [3:0] port);
   route_t                     r;
   sram_port_pkg::macro_port_t mp;
   logic [3:0]                 rd;
   logic                       upper;
   logic                       lower;
   logic                       wide_w;
   logic                       wide_r;
   logic                       split;
   logic                       hit;
   int                         first;   // first port of the side's pair
   int                         own;     // port that drives this macro
   int                         src;     // port that supplies data and bitmask

   r = '0;
   upper = (cfg.mode == sram_cfg_pkg::MODE_TDP_NONSPLIT) && cfg.cascade_enable[1];
   lower = (cfg.mode == sram_cfg_pkg::MODE_TDP_NONSPLIT) && (cfg.cascade_enable == 2'b01);
   split = (cfg.mode == sram_cfg_pkg::MODE_TDP_SPLIT) || (cfg.mode == sram_cfg_pkg::MODE_SDP_SPLIT);
   for (int p = 0; p < 4; p++) begin
      rd[p] = port[p].en && (!port[p].we || cfg.port[p].writemode);
      r.sel[p].re = rd[p];
      if (cfg.mode == sram_cfg_pkg::MODE_TDP_NONSPLIT && (p == 0 || p == 2))
         r.sel[p].ram_select = port[p].addr[6:5];
      else if (cfg.mode == sram_cfg_pkg::MODE_TDP_SPLIT)
         r.sel[p].ram_select = {p == 1 || p == 3, port[p].addr[5]};
   end
   r.casc_a = (upper || lower) && port[0].addr[0];
   r.casc_b = (upper || lower) && port[2].addr[0];

   for (int s = 0; s < 2; s++) begin
      first = 2 * s;
      wide_w = cfg.port[first].input_config == sram_cfg_pkg::WIDTH_40BIT;
      wide_r = cfg.port[first].output_config == sram_cfg_pkg::WIDTH_40BIT;
      for (int m = 0; m < 4; m++) begin
         mp = '0;
         own = split ? first + m / 2 : first;
         src = own;
         case (cfg.mode)
            sram_cfg_pkg::MODE_TDP_NONSPLIT: begin
               if (wide_w && m % 2 == 1) src = first + 1;   // upper half of the 40 bit word
               hit = wide_w ? (int'(port[first].addr[6]) == m / 2) :
                              (int'(port[first].addr[6:5]) == m);
               mp.we = port[first].en && port[first].we && hit;
               hit = wide_r ? (int'(port[first].addr[6]) == m / 2) :
                              (int'(port[first].addr[6:5]) == m);
               mp.re = rd[first] && hit;
               mp.en = mp.we || mp.re;
               if ((upper && !port[first].addr[0]) || (lower && port[first].addr[0])) begin
                  mp.en = 1'b0;
                  mp.we = 1'b0;
               end
            end
            sram_cfg_pkg::MODE_TDP_SPLIT: begin
               hit = int'(port[own].addr[5]) == m % 2;
               mp.en = port[own].en && hit;
               mp.we = port[own].we && hit;   // no en here
               mp.re = rd[own] && hit;
            end
            sram_cfg_pkg::MODE_SDP_NONSPLIT, sram_cfg_pkg::MODE_SDP_SPLIT: begin
               mp.en = port[own].en;
               mp.we = port[own].we;
               mp.re = rd[own];
               if (!split) src = m;   // A0 A1 B0 B1
               else src = (m == 1) ? 2 : (m == 2) ? 1 : m;   // A0 B0 A1 B1
            end
            default: mp = '0;
         endcase
         if (cfg.mode <= sram_cfg_pkg::MODE_SDP_SPLIT) begin
            mp.input_config  = cfg.port[own].input_config;
            mp.output_config = cfg.port[own].output_config;
            mp.set_outputreg = cfg.port[own].set_outputreg;
            mp.addr          = port[own].addr;
            mp.data          = port[src].data;
            mp.bitmask       = port[src].bitmask;
         end
         if (s == 0) r.macro_a[m] = mp;
         else r.macro_b[m] = mp;
      end
   end
   return r;
endfunction

`endif

// File: testbench/tb_mode_selection.sv
/* Testbench of the SRAM port router with directed mode tests followed by random traffic.
   Every output is compared with ref_route once per cycle. */
`timescale 1ns/100ps

module tb_mode_selection;

   logic                             cfg_clk_i;
   logic                             rst_n_i;
   logic                             cfg_we_i;
   sram_cfg_pkg::sram_cfg_t          cfg_i;
   sram_port_pkg::port_req_t [3:0]   port_i;
   sram_port_pkg::macro_port_t [3:0] macro_a_o;
   sram_port_pkg::macro_port_t [3:0] macro_b_o;
   sram_port_pkg::port_sel_t [3:0]   sel_o;
   logic                             a_cascade_select_o;
   logic                             b_cascade_select_o;

   sram_cfg_pkg::sram_cfg_t exp_cfg;         // configuration held by the DUT
   logic [31:0]             rng_state;
   logic                    cmp_en = 1'b0;
   int                      cmp_count = 0;
   time                     cmp_time = 0;
   int                      checks = 0;
   int                      errors = 0;
   int                      test_errors = 0;
   int                      tests_run = 0;
   int                      tests_failed = 0;

   `include "tb_ref_model.svh"

   mode_selection dut0 (
      .cfg_clk_i          (cfg_clk_i),
      .rst_n_i            (rst_n_i),
      .cfg_we_i           (cfg_we_i),
      .cfg_i              (cfg_i),
      .port_i             (port_i),
      .macro_a_o          (macro_a_o),
      .macro_b_o          (macro_b_o),
      .sel_o              (sel_o),
      .a_cascade_select_o (a_cascade_select_o),
      .b_cascade_select_o (b_cascade_select_o)
   );

   initial begin
      cfg_clk_i = 1'b0;
      forever #20 cfg_clk_i = ~cfg_clk_i;
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic compare_outputs();
      route_t e;
      e = ref_route(exp_cfg, port_i);
      for (int m = 0; m < 4; m++) begin
         check_val($sformatf("macro_a_o[%0d]", m), 128'(macro_a_o[m]), 128'(e.macro_a[m]));
         check_val($sformatf("macro_b_o[%0d]", m), 128'(macro_b_o[m]), 128'(e.macro_b[m]));
         check_val($sformatf("sel_o[%0d]", m), 128'(sel_o[m]), 128'(e.sel[m]));
      end
      check_val("a_cascade_select_o", 128'(a_cascade_select_o), 128'(e.casc_a));
      check_val("b_cascade_select_o", 128'(b_cascade_select_o), 128'(e.casc_b));
   endtask

   // outputs are settled 5 ns before the next edge
   initial begin
      forever begin
         @(posedge cfg_clk_i);
         #35;
         if (cmp_en) compare_outputs();
         cmp_time = $time;
         cmp_count++;
      end
   end

   // returns 2 ns after the edge that follows the compare
   task automatic wait_compared();
      int start;
      int waited;
      start = cmp_count;
      waited = 0;
      while (cmp_count == start && waited < 100) begin
         #1;
         waited++;
      end
      if (cmp_count == start) begin
         $display("timeout: the compare process did not sample the outputs within 100 ns");
         $display("FAIL: see errors above");
         $finish;
      end else begin
         #(cmp_time + 7 - $time);
      end
   endtask

   task automatic apply_ports(input sram_port_pkg::port_req_t [3:0] p);
      port_i = p;
      wait_compared();
   endtask

   task automatic load_cfg(input sram_cfg_pkg::sram_cfg_t c);
      cfg_i = c;
      cfg_we_i = 1'b1;
      wait_compared();   // old configuration still routes in this cycle
      cfg_we_i = 1'b0;
      exp_cfg = c;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d mismatches", name, test_errors);
      end
      test_errors = 0;
   endtask

   function automatic sram_port_pkg::port_req_t make_port(input logic en, input logic we,
                                                          input logic [15:0] addr,
                                                          input logic [19:0] data);
      sram_port_pkg::port_req_t r;
      r.en = en;
      r.we = we;
      r.addr = addr;
      r.data = data;
      r.bitmask = data ^ 20'h5a5a5;
      return r;
   endfunction

   function automatic sram_cfg_pkg::sram_cfg_t make_cfg(input logic [2:0] mode,
                                                        input logic [2:0] width,
                                                        input logic [1:0] casc);
      sram_cfg_pkg::sram_cfg_t c;
      c.mode = mode;
      c.cascade_enable = casc;
      for (int p = 0; p < 4; p++) begin
         c.port[p].input_config  = width;
         c.port[p].output_config = width;
         c.port[p].set_outputreg = 1'(p % 2);
         c.port[p].writemode     = 1'(p / 2);
      end
      return c;
   endfunction

   function automatic sram_port_pkg::port_req_t rand_port();
      sram_port_pkg::port_req_t r;
      logic [31:0]              a;
      logic [31:0]              b;
      a = next_rand();
      b = next_rand();
      r.en = a[31];
      r.we = a[30];
      r.addr = a[15:0];
      r.data = b[19:0];
      r.bitmask = {a[29:20], b[31:22]};
      return r;
   endfunction

   function automatic sram_cfg_pkg::sram_cfg_t rand_cfg();
      sram_cfg_pkg::sram_cfg_t c;
      logic [31:0]             a;
      logic [31:0]             b;
      a = next_rand();
      c.mode = a[31] ? {1'b0, a[1:0]} : a[2:0];   // mostly supported modes
      c.cascade_enable = a[4:3];
      for (int p = 0; p < 4; p++) begin
         b = next_rand();
         c.port[p].input_config  = b[0] ? sram_cfg_pkg::WIDTH_40BIT : b[3:1];
         c.port[p].output_config = b[4] ? sram_cfg_pkg::WIDTH_40BIT : b[7:5];
         c.port[p].set_outputreg = b[8];
         c.port[p].writemode     = b[9];
      end
      return c;
   endfunction

   initial begin
      sram_port_pkg::port_req_t [3:0] p;
      rng_state = 32'hbfa0;
      rst_n_i = 1'b0;
      cfg_we_i = 1'b0;
      cfg_i = '0;
      port_i = '0;
      exp_cfg = '0;
      for (int i = 0; i < 16; i++) @(posedge cfg_clk_i);
      #2;
      rst_n_i = 1'b1;
      cmp_en = 1'b1;

      for (int k = 0; k < 4; k++) begin   // no load yet so a narrow write picks one macro
         p = '0;
         p[0] = make_port(1'b1, 1'b1, 16'(k << 5), 20'h12340 + 20'(k));
         p[2] = make_port(1'b1, 1'b0, 16'(k << 5), 20'h0beef);
         apply_ports(p);
         for (int m = 0; m < 4; m++)
            check_val($sformatf("macro_a_o[%0d].we", m), 128'(macro_a_o[m].we), 128'(m == k));
      end
      end_test("reset_tdp_narrow");

      load_cfg(make_cfg(sram_cfg_pkg::MODE_TDP_NONSPLIT, sram_cfg_pkg::WIDTH_40BIT, 2'b00));
      for (int k = 0; k < 2; k++) begin
         p[0] = make_port(1'b1, 1'b1, 16'(k << 6), 20'ha0a00 + 20'(k));
         p[1] = make_port(1'b0, 1'b0, 16'h0000, 20'ha1a1a);
         p[2] = make_port(1'b1, 1'b1, 16'(k << 6) | 16'h0020, 20'hb0b00);
         p[3] = make_port(1'b1, 1'b0, 16'h0040, 20'hb1b1b);
         apply_ports(p);
         check_val("macro_a_o.data odd", 128'(macro_a_o[2 * k + 1].data), 128'(p[1].data));
         check_val("macro_b_o.we pair", 128'({macro_b_o[2 * k].we, macro_b_o[2 * k + 1].we}),
                   128'(2'b11));
      end
      end_test("tdp_wide");

      load_cfg(make_cfg(sram_cfg_pkg::MODE_TDP_SPLIT, 3'd3, 2'b00));
      p[0] = make_port(1'b0, 1'b1, 16'h0020, 20'h0c0c0);   // we without en
      p[1] = make_port(1'b1, 1'b0, 16'h0000, 20'h0c1c1);
      p[2] = make_port(1'b1, 1'b1, 16'h0000, 20'h0d0d0);
      p[3] = make_port(1'b1, 1'b1, 16'h0020, 20'h0d1d1);
      apply_ports(p);
      check_val("macro_a_o[1].we", 128'(macro_a_o[1].we), 128'(1'b1));
      check_val("sel_o[3].ram_select", 128'(sel_o[3].ram_select), 128'(2'b11));
      end_test("tdp_split");

      for (int k = 0; k < 4; k++) begin
         p[k] = make_port(1'b1, 1'(k % 2), 16'(k * 40), 20'h11111 * 20'(k + 1));
      end
      load_cfg(make_cfg(sram_cfg_pkg::MODE_SDP_NONSPLIT, 3'd4, 2'b00));
      apply_ports(p);
      check_val("macro_b_o[1].data", 128'(macro_b_o[1].data), 128'(p[1].data));
      load_cfg(make_cfg(sram_cfg_pkg::MODE_SDP_SPLIT, 3'd4, 2'b00));
      apply_ports(p);
      check_val("macro_a_o[1].data", 128'(macro_a_o[1].data), 128'(p[2].data));
      end_test("sdp_assembly");

      for (int c = 1; c < 3; c++) begin
         load_cfg(make_cfg(sram_cfg_pkg::MODE_TDP_NONSPLIT, 3'd2, 2'(c)));
         for (int k = 0; k < 2; k++) begin
            p[0] = make_port(1'b1, 1'b1, 16'h0040 | 16'(k), 20'h0e0e0);
            p[2] = make_port(1'b1, 1'b0, 16'h0020 | 16'(k), 20'h0f0f0);
            apply_ports(p);
            check_val("a_cascade_select_o", 128'(a_cascade_select_o), 128'(k));
         end
      end
      load_cfg(make_cfg(3'd5, 3'd2, 2'b00));
      apply_ports(p);
      for (int m = 0; m < 4; m++)
         check_val($sformatf("macro_a_o[%0d]", m), 128'(macro_a_o[m]), 128'(0));
      end_test("cascade_and_unsupported");

      for (int i = 0; i < 200; i++) begin
         if (i % 20 == 0) load_cfg(rand_cfg());
         for (int k = 0; k < 4; k++) p[k] = rand_port();
         apply_ports(p);
      end
      end_test("random");

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: src/mode_selection.sv
/* Top of the 4x512x20 SRAM port router, steers ports A0, A1, B0 and B1
   onto the a and b sides of four RAM macros. */
`timescale 1ns/100ps

module mode_selection (
   input  logic                                                        cfg_clk_i,
   input  logic                                                        rst_n_i,
   input  logic                                                        cfg_we_i,
   input  sram_cfg_pkg::sram_cfg_t                                     cfg_i,
   input  sram_port_pkg::port_req_t [sram_port_pkg::NUM_PORTS-1:0]    port_i,
   output sram_port_pkg::macro_port_t [sram_port_pkg::NUM_MACROS-1:0] macro_a_o,
   output sram_port_pkg::macro_port_t [sram_port_pkg::NUM_MACROS-1:0] macro_b_o,
   output sram_port_pkg::port_sel_t [sram_port_pkg::NUM_PORTS-1:0]    sel_o,
   output logic                                                        a_cascade_select_o,
   output logic                                                        b_cascade_select_o
);

   sram_cfg_pkg::sram_cfg_t                cfg;     // registered configuration
   sram_cfg_pkg::mode_flags_t              flags;
   logic [sram_port_pkg::NUM_PORTS-1:0]    rd;      // per-port read request

   mode_decoder mode_decoder0 (
      .cfg_clk_i (cfg_clk_i),
      .rst_n_i   (rst_n_i),
      .cfg_we_i  (cfg_we_i),
      .cfg_i     (cfg_i),
      .cfg_o     (cfg),
      .flags_o   (flags)
   );

   bank_select bank_select0 (
      .flags_i            (flags),
      .cfg_i              (cfg),
      .port_i             (port_i),
      .rd_o               (rd),
      .sel_o              (sel_o),
      .a_cascade_select_o (a_cascade_select_o),
      .b_cascade_select_o (b_cascade_select_o)
   );

   // a side, A0 is the first port of the pair
   side_router router_a (
      .flags_i   (flags),
      .cfg_i     (cfg),
      .own_i     (port_i[sram_port_pkg::PORT_A1:sram_port_pkg::PORT_A0]),
      .own_cfg_i (cfg.port[sram_port_pkg::PORT_A1:sram_port_pkg::PORT_A0]),
      .own_rd_i  (rd[sram_port_pkg::PORT_A1:sram_port_pkg::PORT_A0]),
      .wide_i    (port_i),
      .macro_o   (macro_a_o)
   );

   side_router router_b (
      .flags_i   (flags),
      .cfg_i     (cfg),
      .own_i     (port_i[sram_port_pkg::PORT_B1:sram_port_pkg::PORT_B0]),
      .own_cfg_i (cfg.port[sram_port_pkg::PORT_B1:sram_port_pkg::PORT_B0]),
      .own_rd_i  (rd[sram_port_pkg::PORT_B1:sram_port_pkg::PORT_B0]),
      .wide_i    (port_i),
      .macro_o   (macro_b_o)
   );

endmodule

// File: side_router/side_router.sv
/* Maps one port pair (A0/A1 or B0/B1) onto one side of the four RAM macros.
   Instantiated once per side, the wide inputs carry all four ports for data assembly. */
`timescale 1ns/100ps

module side_router (
   input  sram_cfg_pkg::mode_flags_t                                   flags_i,
   input  sram_cfg_pkg::sram_cfg_t                                     cfg_i,
   input  sram_port_pkg::port_req_t [1:0]                              own_i,
   input  sram_cfg_pkg::port_cfg_t [1:0]                               own_cfg_i,
   input  logic [1:0]                                                  own_rd_i,
   input  sram_port_pkg::port_req_t [sram_port_pkg::NUM_PORTS-1:0]    wide_i,
   output sram_port_pkg::macro_port_t [sram_port_pkg::NUM_MACROS-1:0] macro_o
);

   logic                                 wide_w;       // 40 bit write in tdp non-split
   logic                                 wide_r;
   logic                                 cascade_cut;
   logic [sram_port_pkg::NUM_MACROS-1:0] we_vec;

   assign wide_w = own_cfg_i[0].input_config == sram_cfg_pkg::WIDTH_40BIT;
   assign wide_r = own_cfg_i[0].output_config == sram_cfg_pkg::WIDTH_40BIT;

   // the other cascade half owns this address
   assign cascade_cut = (flags_i.cascade_upper & ~own_i[0].addr[0]) |
                        (flags_i.cascade_lower & own_i[0].addr[0]);

   for (genvar m = 0; m < sram_port_pkg::NUM_MACROS; m++) begin : g_macro
      sram_port_pkg::macro_port_t mp;
      logic                       hit_w;
      logic                       hit_r;
      logic                       hit_s;   // bank hit in tdp split

      // 40 bit uses macro pairs on bit 6, narrow words one macro on bits 6:5
      assign hit_w = wide_w ? (own_i[0].addr[6] == 1'(m / 2)) :
                              (own_i[0].addr[6:5] == 2'(m));
      assign hit_r = wide_r ? (own_i[0].addr[6] == 1'(m / 2)) :
                              (own_i[0].addr[6:5] == 2'(m));
      assign hit_s = own_i[m / 2].addr[5] == 1'(m % 2);

      always_comb begin
         mp = '0;
         case (cfg_i.mode)
            sram_cfg_pkg::MODE_TDP_NONSPLIT: begin
               mp.input_config  = own_cfg_i[0].input_config;
               mp.output_config = own_cfg_i[0].output_config;
               mp.set_outputreg = own_cfg_i[0].set_outputreg;
               mp.addr          = own_i[0].addr;
               // upper half of a 40 bit word comes from the partner port
               mp.data          = wide_w ? own_i[m % 2].data : own_i[0].data;
               mp.bitmask       = wide_w ? own_i[m % 2].bitmask : own_i[0].bitmask;
               mp.we            = own_i[0].en & own_i[0].we & hit_w;
               mp.re            = own_rd_i[0] & hit_r;
               mp.en            = (mp.we | mp.re) & ~cascade_cut;
               mp.we            = mp.we & ~cascade_cut;   // re stays for the deselector
            end
            sram_cfg_pkg::MODE_TDP_SPLIT: begin
               // macros 1-2 serve the first port, 3-4 the second
               mp.input_config  = own_cfg_i[m / 2].input_config;
               mp.output_config = own_cfg_i[m / 2].output_config;
               mp.set_outputreg = own_cfg_i[m / 2].set_outputreg;
               mp.en            = own_i[m / 2].en & hit_s;
               mp.we            = own_i[m / 2].we & hit_s;   // not qualified by en
               mp.re            = own_rd_i[m / 2] & hit_s;
               mp.addr          = own_i[m / 2].addr;
               mp.data          = own_i[m / 2].data;
               mp.bitmask       = own_i[m / 2].bitmask;
            end
            sram_cfg_pkg::MODE_SDP_NONSPLIT: begin
               mp.input_config  = own_cfg_i[0].input_config;
               mp.output_config = own_cfg_i[0].output_config;
               mp.set_outputreg = own_cfg_i[0].set_outputreg;
               mp.en            = own_i[0].en;
               mp.we            = own_i[0].we;
               mp.re            = own_rd_i[0];
               mp.addr          = own_i[0].addr;
               mp.data          = wide_i[m].data;      // A0, A1, B0, B1
               mp.bitmask       = wide_i[m].bitmask;
            end
            sram_cfg_pkg::MODE_SDP_SPLIT: begin
               mp.input_config  = own_cfg_i[m / 2].input_config;
               mp.output_config = own_cfg_i[m / 2].output_config;
               mp.set_outputreg = own_cfg_i[m / 2].set_outputreg;
               mp.en            = own_i[m / 2].en;
               mp.we            = own_i[m / 2].we;
               mp.re            = own_rd_i[m / 2];
               mp.addr          = own_i[m / 2].addr;
               // A0, B0, A1, B1
               mp.data          = wide_i[(m % 2) * 2 + m / 2].data;
               mp.bitmask       = wide_i[(m % 2) * 2 + m / 2].bitmask;
            end
            default: begin
               mp = '0;
            end
         endcase
      end

      assign macro_o[m] = mp;
      assign we_vec[m]  = mp.we;
   end

   // decoder flags and the registered mode must agree on the narrow write path
   always_comb begin
      if (flags_i.tdp_nonsplit && !wide_w) begin
         narrow_we_single: assert #0 ($onehot0(we_vec))
            else $error("narrow tdp write reaches more than one macro");
      end
   end

endmodule

// File: src/bank_select.sv
/* Per-port read requests, RAM select and cascade select of the SRAM router.
   The read requests also feed both side routers. */
`timescale 1ns/100ps

module bank_select (
   input  sram_cfg_pkg::mode_flags_t                                flags_i,
   input  sram_cfg_pkg::sram_cfg_t                                  cfg_i,
   input  sram_port_pkg::port_req_t [sram_port_pkg::NUM_PORTS-1:0] port_i,
   output logic [sram_port_pkg::NUM_PORTS-1:0]                      rd_o,
   output sram_port_pkg::port_sel_t [sram_port_pkg::NUM_PORTS-1:0] sel_o,
   output logic                                                     a_cascade_select_o,
   output logic                                                     b_cascade_select_o
);

   logic cascade_on;

   always_comb begin
      for (int p = 0; p < sram_port_pkg::NUM_PORTS; p++) begin
         // read unless writing, writemode allows read during write
         rd_o[p] = port_i[p].en & (~port_i[p].we | cfg_i.port[p].writemode);
         sel_o[p].re = rd_o[p];

         if (flags_i.tdp_nonsplit) begin
            // only the first port of a pair is used in non-split
            sel_o[p].ram_select = (p % 2 == 0) ? port_i[p].addr[6:5] : 2'd0;
         end else if (flags_i.tdp_split) begin
            sel_o[p].ram_select = {1'(p % 2), port_i[p].addr[5]};   // high flag, then bank
         end else begin
            sel_o[p].ram_select = 2'd0;   // sdp reads all macros at once
         end
      end
   end

   assign cascade_on = flags_i.tdp_nonsplit &
                       (flags_i.cascade_upper | flags_i.cascade_lower);

   // address bit 0 picks the cascade half that returns the data
   assign a_cascade_select_o = cascade_on & port_i[sram_port_pkg::PORT_A0].addr[0];
   assign b_cascade_select_o = cascade_on & port_i[sram_port_pkg::PORT_B0].addr[0];

endmodule

// File: src/mode_decoder.sv
/* Configuration register of the SRAM router and the mode decode.
   Loads on cfg_we_i, all other blocks route from its outputs. */
`timescale 1ns/100ps

module mode_decoder (
   input  logic                     cfg_clk_i,
   input  logic                     rst_n_i,
   input  logic                     cfg_we_i,
   input  sram_cfg_pkg::sram_cfg_t  cfg_i,
   output sram_cfg_pkg::sram_cfg_t  cfg_o,
   output sram_cfg_pkg::mode_flags_t flags_o
);

   sram_cfg_pkg::sram_cfg_t cfg_q;

   // all zero after reset, TDP non-split without cascade
   always_ff @(posedge cfg_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cfg_q <= '0;
      end else if (cfg_we_i) begin
         cfg_q <= cfg_i;
      end
   end

   assign cfg_o = cfg_q;

   always_comb begin
      flags_o = '0;
      case (cfg_q.mode)
         sram_cfg_pkg::MODE_TDP_NONSPLIT: begin
            flags_o.tdp_nonsplit = 1'b1;
         end
         sram_cfg_pkg::MODE_TDP_SPLIT: begin
            flags_o.tdp_split = 1'b1;
         end
         sram_cfg_pkg::MODE_SDP_NONSPLIT: begin
            flags_o.sdp_nonsplit = 1'b1;
         end
         sram_cfg_pkg::MODE_SDP_SPLIT: begin
            flags_o.sdp_split = 1'b1;
         end
         default: begin
            flags_o = '0;   // fifo and cascade codes, routers drive zeros
         end
      endcase

      // cascading only exists in tdp non-split, upper wins over lower
      flags_o.cascade_upper = flags_o.tdp_nonsplit & cfg_q.cascade_enable[1];
      flags_o.cascade_lower = flags_o.tdp_nonsplit & ~cfg_q.cascade_enable[1] &
                              cfg_q.cascade_enable[0];
   end

   // both routers and the bank selector rely on a single active mode
   mode_onehot: assert property (
      @(posedge cfg_clk_i) disable iff (!rst_n_i)
      $onehot0({flags_o.tdp_nonsplit, flags_o.tdp_split,
                flags_o.sdp_nonsplit, flags_o.sdp_split})
   ) else $error("more than one memory mode flag set");

endmodule

// File: common/sram_port_pkg.sv
/* Port side types of the SRAM router: logical port requests,
   one side of a RAM macro and the read-back deselect word. */
package sram_port_pkg;

   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 20;
   localparam int NUM_PORTS  = 4;
   localparam int NUM_MACROS = 4;

   // logical port order in every port array
   localparam int PORT_A0 = 0;
   localparam int PORT_A1 = 1;
   localparam int PORT_B0 = 2;
   localparam int PORT_B1 = 3;

   // one logical port request, 58 bits
   typedef struct packed {
      logic              en;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [DATA_W-1:0] bitmask;
   } port_req_t;

   // one side (a or b) of one RAM macro, 66 bits
   typedef struct packed {
      logic [sram_cfg_pkg::CFG_W-1:0] input_config;
      logic [sram_cfg_pkg::CFG_W-1:0] output_config;
      logic                           set_outputreg;
      logic                           en;
      logic                           we;
      logic                           re;
      logic [ADDR_W-1:0]              addr;
      logic [DATA_W-1:0]              data;
      logic [DATA_W-1:0]              bitmask;
   } macro_port_t;

   // what the read-back deselector needs per port
   typedef struct packed {
      logic [1:0] ram_select;   // macro that returns the read data
      logic       re;
   } port_sel_t;

endpackage

// File: common/sram_cfg_pkg.sv
/* Configuration codes and types of the 4x512x20 SRAM port router.
   Compile before sram_port_pkg, which takes the config field width from here. */
package sram_cfg_pkg;

   localparam int CFG_W  = 3;    // width of a port config code
   localparam int MODE_W = 3;

   // memory modes, the FIFO and cascade codes are not routed
   localparam logic [MODE_W-1:0] MODE_TDP_NONSPLIT = 3'd0;
   localparam logic [MODE_W-1:0] MODE_TDP_SPLIT    = 3'd1;
   localparam logic [MODE_W-1:0] MODE_SDP_NONSPLIT = 3'd2;
   localparam logic [MODE_W-1:0] MODE_SDP_SPLIT    = 3'd3;

   // only the 40 bit code changes the routing, narrower codes are passed on
   localparam logic [CFG_W-1:0] WIDTH_40BIT = 3'd6;

   // configuration of one logical port
   typedef struct packed {
      logic [CFG_W-1:0] input_config;
      logic [CFG_W-1:0] output_config;
      logic             set_outputreg;
      logic             writemode;       // read while writing
   } port_cfg_t;

   // whole block configuration, 37 bits
   typedef struct packed {
      logic [MODE_W-1:0] mode;
      port_cfg_t [3:0]   port;            // 0 is A0, 1 A1, 2 B0, 3 B1
      logic [1:0]        cascade_enable;  // [1] upper, [0] lower
   } sram_cfg_t;

   /* decoded mode, at most one of the first four is set
      and the cascade flags only come with tdp_nonsplit */
   typedef struct packed {
      logic tdp_nonsplit;
      logic tdp_split;
      logic sdp_nonsplit;
      logic sdp_split;
      logic cascade_upper;
      logic cascade_lower;
   } mode_flags_t;

endpackage
